// File: hw/pkt_gen_pkg.sv
// Packet generator shared definitions
`default_nettype none

package pkt_gen_pkg;

    // ----------------------------------------
    // Data widths and table depths
    // ----------------------------------------
    localparam int SAMPLE_W = 9;
    localparam int WORD_W   = 4 * SAMPLE_W;
    localparam int DEPTH_96 = 24;
    localparam int DEPTH_48 = 12;
    localparam int ADDR_W   = 5;

    typedef enum logic {
        RATE_96 = 1'b0,
        RATE_48 = 1'b1
    } rate_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_TRAILER
    } framer_state_e;

    // ----------------------------------------
    // Header word layout
    // ----------------------------------------
    localparam logic [3:0] PKT_TAG = 4'hA;

    localparam int HDR_TAG_LSB  = 32;
    localparam int HDR_TAG_W    = 4;
    localparam int HDR_SEQ_LSB  = 24;
    localparam int HDR_SEQ_W    = 8;
    localparam int HDR_LEN_LSB  = 16;
    localparam int HDR_LEN_W    = 8;
    // Set for the 48-point table, bits below it stay zero
    localparam int HDR_RATE_BIT = 15;

endpackage

`default_nettype wire

// File: hw/sine_table.sv
// Sine pattern lookup tables
`timescale 1ns/1ns
`default_nettype none

module sine_table import pkt_gen_pkg::*; (
    input  wire               clk,
    input  wire               rd_en,
    input  wire rate_e        rd_rate,
    input  wire  [ADDR_W-1:0] rd_addr,
    output logic [WORD_W-1:0] rd_data
);

    logic [WORD_W-1:0] word_96;
    logic [WORD_W-1:0] word_48;

    // 96 points, four samples per word, first sample in the low bits
    always_comb begin
        case (rd_addr)
            0:       word_96 = {9'h131, 9'h121, 9'h110, 9'h0FF};
            1:       word_96 = {9'h171, 9'h162, 9'h152, 9'h142};
            2:       word_96 = {9'h1A9, 9'h19C, 9'h18E, 9'h180};
            3:       word_96 = {9'h1D4, 9'h1CB, 9'h1C0, 9'h1B5};
            4:       word_96 = {9'h1F2, 9'h1EC, 9'h1E5, 9'h1DD};
            5:       word_96 = {9'h1FE, 9'h1FC, 9'h1FA, 9'h1F6};
            6:       word_96 = {9'h1F8, 9'h1FB, 9'h1FD, 9'h1FE};
            7:       word_96 = {9'h1E1, 9'h1E9, 9'h1EF, 9'h1F4};
            8:       word_96 = {9'h1BB, 9'h1C6, 9'h1D0, 9'h1D9};
            9:       word_96 = {9'h187, 9'h195, 9'h1A2, 9'h1AF};
            10:      word_96 = {9'h14A, 9'h15A, 9'h169, 9'h178};
            11:      word_96 = {9'h107, 9'h118, 9'h129, 9'h13A};
            12:      word_96 = {9'h0C4, 9'h0D5, 9'h0E6, 9'h0F7};
            13:      word_96 = {9'h086, 9'h095, 9'h0A4, 9'h0B4};
            14:      word_96 = {9'h04F, 9'h05C, 9'h069, 9'h077};
            15:      word_96 = {9'h025, 9'h02E, 9'h038, 9'h043};
            16:      word_96 = {9'h00A, 9'h00F, 9'h015, 9'h01D};
            17:      word_96 = {9'h000, 9'h001, 9'h003, 9'h006};
            18:      word_96 = {9'h008, 9'h004, 9'h002, 9'h000};
            19:      word_96 = {9'h021, 9'h019, 9'h012, 9'h00C};
            20:      word_96 = {9'h049, 9'h03E, 9'h033, 9'h02A};
            21:      word_96 = {9'h07E, 9'h070, 9'h062, 9'h055};
            22:      word_96 = {9'h0BC, 9'h0AC, 9'h09C, 9'h08D};
            23:      word_96 = {9'h0FF, 9'h0EE, 9'h0DD, 9'h0CD};
            default: word_96 = '0;
        endcase
    end

    // 48 points, same packing
    always_comb begin
        case (rd_addr)
            0:       word_48 = {9'h163, 9'h142, 9'h121, 9'h0FF};
            1:       word_48 = {9'h1CC, 9'h1B6, 9'h19D, 9'h181};
            2:       word_48 = {9'h1FD, 9'h1F7, 9'h1ED, 9'h1DF};
            3:       word_48 = {9'h1E6, 9'h1F3, 9'h1FA, 9'h1FE};
            4:       word_48 = {9'h18F, 9'h1AA, 9'h1C2, 9'h1D6};
            5:       word_48 = {9'h110, 9'h132, 9'h153, 9'h172};
            6:       word_48 = {9'h08C, 9'h0AB, 9'h0CC, 9'h0EE};
            7:       word_48 = {9'h028, 9'h03C, 9'h054, 9'h06F};
            8:       word_48 = {9'h000, 9'h004, 9'h00B, 9'h018};
            9:       word_48 = {9'h01F, 9'h011, 9'h007, 9'h001};
            10:      word_48 = {9'h07D, 9'h061, 9'h048, 9'h032};
            11:      word_48 = {9'h0FF, 9'h0DD, 9'h0BC, 9'h09B};
            default: word_48 = '0;
        endcase
    end

    // Registered read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= (rd_rate == RATE_48) ? word_48 : word_96;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_sequencer.sv
// Sine payload sequencer
`timescale 1ns/1ns
`default_nettype none

module sample_sequencer import pkt_gen_pkg::*; #(
    parameter int LEN_W = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               job_valid,
    output logic              job_ready,
    input  wire rate_e        job_rate,
    input  wire  [LEN_W-1:0]  job_len,
    output logic              rd_en,
    output rate_e             rd_rate,
    output logic [ADDR_W-1:0] rd_addr,
    input  wire  [WORD_W-1:0] rd_data,
    output logic              smp_valid,
    input  wire               smp_ready,
    output logic [WORD_W-1:0] smp_data,
    output logic              smp_last
);

    logic              busy;
    rate_e             rate_q;
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] last_addr;
    logic [LEN_W-1:0]  remain;
    logic              inflight;
    logic              inflight_last;
    logic [WORD_W-1:0] fifo_data [2];
    logic              fifo_last [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        fifo_cnt;
    logic [1:0]        occupancy;
    logic              pop;

    assign job_ready = !busy;
    assign pop       = smp_valid && smp_ready;

    // Buffered plus in-flight words, at most two
    assign occupancy = fifo_cnt + {1'b0, inflight};
    assign rd_en     = busy && (remain != '0) && ((occupancy < 2'd2) || pop);
    assign rd_rate   = rate_q;
    assign rd_addr   = addr_q;
    assign last_addr = (rate_q == RATE_48) ? ADDR_W'(DEPTH_48 - 1) : ADDR_W'(DEPTH_96 - 1);

    // ----------------------------------------
    // Job tracking and address walk
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            remain <= '0;
        end else if (job_valid && job_ready) begin
            busy   <= 1'b1;
            remain <= job_len;
        end else begin
            if (rd_en) begin
                remain <= remain - 1'b1;
            end
            // Idle again once the final word has left
            if (pop && smp_last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            rate_q <= job_rate;
            addr_q <= '0;
        end else if (rd_en) begin
            addr_q <= (addr_q == last_addr) ? '0 : addr_q + 1'b1;
        end
    end

    // ----------------------------------------
    // Read return and two-entry output FIFO
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= 1'b0;
        end else begin
            inflight <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            inflight_last <= (remain == LEN_W'(1));
        end
        if (inflight) begin
            fifo_data[wr_ptr] <= rd_data;
            fifo_last[wr_ptr] <= inflight_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            fifo_cnt <= '0;
        end else begin
            if (inflight) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            fifo_cnt <= fifo_cnt + {1'b0, inflight} - {1'b0, pop};
        end
    end

    assign smp_valid = (fifo_cnt != 2'd0);
    assign smp_data  = fifo_data[rd_ptr];
    assign smp_last  = fifo_last[rd_ptr];

endmodule

`default_nettype wire

// File: hw/pkt_framer.sv
// Packet framer with checksum trailer
`timescale 1ns/1ns
`default_nettype none

module pkt_framer import pkt_gen_pkg::*; #(
    parameter int LEN_W = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               cmd_valid,
    output logic              cmd_ready,
    input  wire rate_e        cmd_rate,
    input  wire  [LEN_W-1:0]  cmd_len,
    output logic              pkt_valid,
    input  wire               pkt_ready,
    output logic [WORD_W-1:0] pkt_data,
    output logic              pkt_sop,
    output logic              pkt_eop,
    output logic              job_valid,
    input  wire               job_ready,
    output rate_e             job_rate,
    output logic [LEN_W-1:0]  job_len,
    input  wire               smp_valid,
    output logic              smp_ready,
    input  wire  [WORD_W-1:0] smp_data,
    input  wire               smp_last
);

    framer_state_e        state_q;
    framer_state_e        state_d;
    rate_e                rate_q;
    logic [LEN_W-1:0]     len_q;
    logic [HDR_SEQ_W-1:0] seq_q;
    logic [WORD_W-1:0]    csum_q;
    logic [WORD_W-1:0]    header;
    logic                 cmd_fire;
    logic                 pkt_fire;

    assign cmd_ready = (state_q == ST_IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign pkt_fire  = pkt_valid && pkt_ready;
    assign pkt_sop   = (state_q == ST_HEADER);
    assign pkt_eop   = (state_q == ST_TRAILER);

    // Payload stalls go straight back to the sequencer
    assign smp_ready = (state_q == ST_PAYLOAD) && pkt_ready;
    assign job_rate  = rate_q;
    assign job_len   = len_q;

    always_comb begin
        header = '0;
        header[HDR_TAG_LSB +: HDR_TAG_W] = PKT_TAG;
        header[HDR_SEQ_LSB +: HDR_SEQ_W] = seq_q;
        header[HDR_LEN_LSB +: HDR_LEN_W] = HDR_LEN_W'(len_q);
        header[HDR_RATE_BIT]             = (rate_q == RATE_48);
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_fire) begin
                    state_d = ST_HEADER;
                end
            end
            ST_HEADER: begin
                if (pkt_ready) begin
                    state_d = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (pkt_fire && smp_last) begin
                    state_d = ST_TRAILER;
                end
            end
            ST_TRAILER: begin
                if (pkt_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        pkt_valid = 1'b0;
        pkt_data  = header;
        case (state_q)
            ST_HEADER:  pkt_valid = 1'b1;
            ST_PAYLOAD: begin
                pkt_valid = smp_valid;
                pkt_data  = smp_data;
            end
            ST_TRAILER: begin
                pkt_valid = 1'b1;
                pkt_data  = csum_q;
            end
            default: pkt_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            seq_q     <= '0;
            job_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            // One count per finished packet, wraps at 8 bits
            if (pkt_fire && pkt_eop) begin
                seq_q <= seq_q + 1'b1;
            end
            if (cmd_fire) begin
                job_valid <= 1'b1;
            end else if (job_ready) begin
                job_valid <= 1'b0;
            end
        end
    end

    // Command fields and running XOR of payload words
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            rate_q <= cmd_rate;
            len_q  <= cmd_len;
            csum_q <= '0;
        end else if (pkt_fire && (state_q == ST_PAYLOAD)) begin
            csum_q <= csum_q ^ smp_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/package_gen_top.sv
// Sine packet generator top level
`timescale 1ns/1ns
`default_nettype none

module package_gen_top import pkt_gen_pkg::*; #(
    parameter int LEN_W = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               cmd_valid,
    output logic              cmd_ready,
    input  wire rate_e        cmd_rate,
    input  wire  [LEN_W-1:0]  cmd_len,
    output logic              pkt_valid,
    input  wire               pkt_ready,
    output logic [WORD_W-1:0] pkt_data,
    output logic              pkt_sop,
    output logic              pkt_eop
);

    // Job link
    logic              job_valid;
    logic              job_ready;
    rate_e             job_rate;
    logic [LEN_W-1:0]  job_len;

    // Sample link
    logic              smp_valid;
    logic              smp_ready;
    logic [WORD_W-1:0] smp_data;
    logic              smp_last;

    // Table read
    logic              rd_en;
    rate_e             rd_rate;
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] rd_data;

    pkt_framer #(
        .LEN_W (LEN_W)
    ) pkt_framer_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_rate  (cmd_rate),
        .cmd_len   (cmd_len),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt_data  (pkt_data),
        .pkt_sop   (pkt_sop),
        .pkt_eop   (pkt_eop),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job_rate  (job_rate),
        .job_len   (job_len),
        .smp_valid (smp_valid),
        .smp_ready (smp_ready),
        .smp_data  (smp_data),
        .smp_last  (smp_last)
    );

    sample_sequencer #(
        .LEN_W (LEN_W)
    ) sample_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job_rate  (job_rate),
        .job_len   (job_len),
        .rd_en     (rd_en),
        .rd_rate   (rd_rate),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .smp_valid (smp_valid),
        .smp_ready (smp_ready),
        .smp_data  (smp_data),
        .smp_last  (smp_last)
    );

    sine_table sine_table_inst (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_rate (rd_rate),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: sim/package_gen_props.sv
// Packet output protocol checks
`timescale 1ns/1ns
`default_nettype none

module package_gen_props import pkt_gen_pkg::*; (
    input wire              clk,
    input wire              rst,
    input wire              cmd_ready,
    input wire              pkt_valid,
    input wire              pkt_ready,
    input wire [WORD_W-1:0] pkt_data,
    input wire              pkt_sop,
    input wire              pkt_eop
);

    int violations = 0;

    // Valid stays up until the word is taken
    valid_held: assert property (@(posedge clk) disable iff (rst)
        pkt_valid && !pkt_ready |=> pkt_valid)
        else begin
            $error("pkt_valid dropped before the word was transferred");
            violations++;
        end

    // Stalled word holds data and framing flags
    word_stable: assert property (@(posedge clk) disable iff (rst)
        pkt_valid && !pkt_ready |=> $stable(pkt_data) && $stable(pkt_sop) && $stable(pkt_eop))
        else begin
            $error("pkt_data, pkt_sop or pkt_eop changed while stalled");
            violations++;
        end

    sop_eop_apart: assert property (@(posedge clk) disable iff (rst)
        !(pkt_sop && pkt_eop))
        else begin
            $error("pkt_sop and pkt_eop both high");
            violations++;
        end

    // No new command while a word is on the output
    cmd_blocked: assert property (@(posedge clk) disable iff (rst)
        !(cmd_ready && pkt_valid))
        else begin
            $error("cmd_ready high while pkt_valid is high");
            violations++;
        end

endmodule

`default_nettype wire

// File: sim/package_gen_tb.sv
// Sine packet generator testbench
`timescale 1ns/1ns
`default_nettype none

module package_gen_tb import pkt_gen_pkg::*;;

    localparam int LEN_W = 8;
    // Header, payload and trailer words summed over all tests
    localparam int TOTAL_WORDS = (6 + 7) + 32 + (14 + 15) + (3 + 26)
                               + (32 + 15 + 9 + 52) + (3 + 257 + 257);
    localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 500;

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    logic              cmd_ready;
    rate_e             cmd_rate;
    logic [LEN_W-1:0]  cmd_len;
    logic              pkt_valid;
    logic              pkt_ready;
    logic [WORD_W-1:0] pkt_data;
    logic              pkt_sop;
    logic              pkt_eop;

    // Expected words as {sop, eop, data}
    logic [WORD_W+1:0] exp_q [$];
    logic [WORD_W+1:0] exp_entry;
    bit                have_entry;
    bit                trailer_done;
    logic [31:0]       rng_state;
    bit                ready_random;
    int                errors;
    int                cmd_count;
    int                cycles;
    int                tests_run;
    int                tests_failed;
    int                fault_mark;

    package_gen_top #(
        .LEN_W (LEN_W)
    ) package_gen_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_rate  (cmd_rate),
        .cmd_len   (cmd_len),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt_data  (pkt_data),
        .pkt_sop   (pkt_sop),
        .pkt_eop   (pkt_eop)
    );

    bind package_gen_top package_gen_props package_gen_props_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_ready (cmd_ready),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt_data  (pkt_data),
        .pkt_sop   (pkt_sop),
        .pkt_eop   (pkt_eop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    // Table copy with the first sample in the low 9 bits
    function automatic logic [WORD_W-1:0] ref_word(input rate_e rate, input int idx);
        logic [WORD_W-1:0] w;
        if (rate == RATE_48) begin
            case (idx)
                0:       w = {9'h163, 9'h142, 9'h121, 9'h0FF};
                1:       w = {9'h1CC, 9'h1B6, 9'h19D, 9'h181};
                2:       w = {9'h1FD, 9'h1F7, 9'h1ED, 9'h1DF};
                3:       w = {9'h1E6, 9'h1F3, 9'h1FA, 9'h1FE};
                4:       w = {9'h18F, 9'h1AA, 9'h1C2, 9'h1D6};
                5:       w = {9'h110, 9'h132, 9'h153, 9'h172};
                6:       w = {9'h08C, 9'h0AB, 9'h0CC, 9'h0EE};
                7:       w = {9'h028, 9'h03C, 9'h054, 9'h06F};
                8:       w = {9'h000, 9'h004, 9'h00B, 9'h018};
                9:       w = {9'h01F, 9'h011, 9'h007, 9'h001};
                10:      w = {9'h07D, 9'h061, 9'h048, 9'h032};
                11:      w = {9'h0FF, 9'h0DD, 9'h0BC, 9'h09B};
                default: w = '0;
            endcase
        end else begin
            case (idx)
                0:       w = {9'h131, 9'h121, 9'h110, 9'h0FF};
                1:       w = {9'h171, 9'h162, 9'h152, 9'h142};
                2:       w = {9'h1A9, 9'h19C, 9'h18E, 9'h180};
                3:       w = {9'h1D4, 9'h1CB, 9'h1C0, 9'h1B5};
                4:       w = {9'h1F2, 9'h1EC, 9'h1E5, 9'h1DD};
                5:       w = {9'h1FE, 9'h1FC, 9'h1FA, 9'h1F6};
                6:       w = {9'h1F8, 9'h1FB, 9'h1FD, 9'h1FE};
                7:       w = {9'h1E1, 9'h1E9, 9'h1EF, 9'h1F4};
                8:       w = {9'h1BB, 9'h1C6, 9'h1D0, 9'h1D9};
                9:       w = {9'h187, 9'h195, 9'h1A2, 9'h1AF};
                10:      w = {9'h14A, 9'h15A, 9'h169, 9'h178};
                11:      w = {9'h107, 9'h118, 9'h129, 9'h13A};
                12:      w = {9'h0C4, 9'h0D5, 9'h0E6, 9'h0F7};
                13:      w = {9'h086, 9'h095, 9'h0A4, 9'h0B4};
                14:      w = {9'h04F, 9'h05C, 9'h069, 9'h077};
                15:      w = {9'h025, 9'h02E, 9'h038, 9'h043};
                16:      w = {9'h00A, 9'h00F, 9'h015, 9'h01D};
                17:      w = {9'h000, 9'h001, 9'h003, 9'h006};
                18:      w = {9'h008, 9'h004, 9'h002, 9'h000};
                19:      w = {9'h021, 9'h019, 9'h012, 9'h00C};
                20:      w = {9'h049, 9'h03E, 9'h033, 9'h02A};
                21:      w = {9'h07E, 9'h070, 9'h062, 9'h055};
                22:      w = {9'h0BC, 9'h0AC, 9'h09C, 9'h08D};
                23:      w = {9'h0FF, 9'h0EE, 9'h0DD, 9'h0CD};
                default: w = '0;
            endcase
        end
        return w;
    endfunction

    function automatic int total_faults();
        return errors + package_gen_top_inst.package_gen_props_inst.violations;
    endfunction

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    // Hold keeps cmd_valid up so the next command waits behind this packet
    task automatic send_cmd(input rate_e rate, input int len, input bit hold);
        logic [WORD_W-1:0] word;
        logic [WORD_W-1:0] csum;
        int                depth;
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd_rate  = rate;
        cmd_len   = len[LEN_W-1:0];
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else begin
            $display("Command accepted while the previous packet was still in progress");
            errors++;
        end
        depth = (rate == RATE_48) ? 12 : 24;
        exp_q.push_back({2'b10, 4'hA, cmd_count[7:0], len[7:0], rate == RATE_48, 15'h0});
        csum = '0;
        for (int k = 0; k < len; k++) begin
            word = ref_word(rate, k % depth);
            csum ^= word;
            exp_q.push_back({2'b00, word});
        end
        exp_q.push_back({2'b01, csum});
        cmd_count++;
        // Header is due on the cycle after acceptance
        @(negedge clk);
        assert (pkt_valid && pkt_sop) else begin
            $display("Header not presented on the cycle after the command was accepted");
            errors++;
        end
        if (!hold) begin
            @(posedge clk);
            #1;
            cmd_valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (total_faults() != fault_mark) begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d new faults", tests_run, name, total_faults() - fault_mark);
        fault_mark = total_faults();
    endtask

    // Random or constant output ready
    always @(posedge clk) begin
        #1;
        rng_state = xorshift32(rng_state);
        if (ready_random) begin
            pkt_ready = (rng_state[1:0] != 2'b00);
        end else begin
            pkt_ready = 1'b1;
        end
    end

    // ----------------------------------------
    // Output monitor sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin
        // Command input reopens on the cycle after the trailer
        if (trailer_done) begin
            assert (cmd_ready === 1'b1) else begin
                $display("FAILED cmd_ready: expected %h, got %h", 1'b1, cmd_ready);
                errors++;
            end
        end
        trailer_done = 1'b0;
        if (!rst && pkt_valid && pkt_ready) begin
            have_entry = (exp_q.size() != 0);
            assert (have_entry) else begin
                $display("Packet word %h transferred with no packet outstanding", pkt_data);
                errors++;
            end
            if (have_entry) begin
                exp_entry = exp_q.pop_front();
                trailer_done = exp_entry[WORD_W];
                assert (pkt_data === exp_entry[WORD_W-1:0]) else begin
                    $display("FAILED pkt_data: expected %h, got %h",
                             exp_entry[WORD_W-1:0], pkt_data);
                    errors++;
                end
                assert (pkt_sop === exp_entry[WORD_W+1]) else begin
                    $display("FAILED pkt_sop: expected %h, got %h", exp_entry[WORD_W+1], pkt_sop);
                    errors++;
                end
                assert (pkt_eop === exp_entry[WORD_W]) else begin
                    $display("FAILED pkt_eop: expected %h, got %h", exp_entry[WORD_W], pkt_eop);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d words still expected",
                     cycles, exp_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_rate     = RATE_96;
        cmd_len      = '0;
        pkt_ready    = 1'b0;
        ready_random = 1'b0;
        trailer_done = 1'b0;
        rng_state    = 32'd93068;
        errors       = 0;
        cmd_count    = 0;
        cycles       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fault_mark   = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        send_cmd(RATE_96, 4, 1'b0);
        wait_idle();
        send_cmd(RATE_48, 5, 1'b0);
        wait_idle();
        finish_test("header fields and sequence");

        send_cmd(RATE_96, 30, 1'b0);
        wait_idle();
        finish_test("payload wrap at 96 points");

        send_cmd(RATE_48, 12, 1'b0);
        wait_idle();
        send_cmd(RATE_48, 13, 1'b0);
        wait_idle();
        finish_test("payload wrap at 48 points");

        send_cmd(RATE_96, 1, 1'b0);
        wait_idle();
        send_cmd(RATE_96, 24, 1'b0);
        wait_idle();
        finish_test("trailer checksum and length");

        // Random stalls from here on
        ready_random = 1'b1;
        send_cmd(RATE_96, 30, 1'b0);
        wait_idle();
        send_cmd(RATE_48, 13, 1'b0);
        wait_idle();
        send_cmd(RATE_96, 7, 1'b0);
        wait_idle();
        send_cmd(RATE_48, 50, 1'b0);
        wait_idle();
        finish_test("back-pressure");

        send_cmd(RATE_96, 1, 1'b1);
        send_cmd(RATE_48, 255, 1'b1);
        send_cmd(RATE_96, 255, 1'b0);
        wait_idle();
        finish_test("held commands, lengths 1 and 255");

        repeat (4) @(posedge clk);
        $display("Tests run %0d, failed %0d, word errors %0d, protocol violations %0d",
                 tests_run, tests_failed, errors,
                 package_gen_top_inst.package_gen_props_inst.violations);
        if (total_faults() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/pkt_gen_pkg.sv
hw/sine_table.sv
hw/sample_sequencer.sv
hw/pkt_framer.sv
hw/package_gen_top.sv
sim/package_gen_props.sv
sim/package_gen_tb.sv
